//--- flist.f
common/rv_pkg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/alu.sv
hw/int_core.sv
sim/int_core_checker.sv
sim/tb_int_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_int_core
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_int_core.sv
`timescale 1ns/100ps

module tb_int_core import rv_pkg::*; ();

    // About 670 issues plus reset and idle gaps.
    localparam int max_cycles = 2000;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    inst_t       inst;
    logic        wb_valid;
    reg_idx_t    wb_rd;
    word_t       wb_data;
    logic        illegal;
    int          checks;
    int          errors;
    int          cycles = 0;
    logic [15:0] lfsr;
    logic [31:0] rnd;
    reg_idx_t    last_rd;

    int_core u_int_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    int_core_checker u_int_core_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal),
        .checks     (checks),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    task automatic issue(input inst_t i);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = i;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst       = '0;
        end
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 32; r++) begin
            issue(enc_i(12'h000, reg_idx_t'(r), f3_or, reg_idx_t'(r)));  // ori xr, xr, 0.
        end
    endtask

    task automatic random_op();
        logic [2:0] f3;
        rnd     = rand_bits(20);
        f3      = rnd[2:0];
        issue(enc_r((rnd[3] && (f3 == f3_add_sub || f3 == f3_srl_sra)) ? f7_alt : f7_base,
                    rnd[18:14], rnd[19] ? last_rd : rnd[13:9], f3, rnd[8:4]));
        last_rd = rnd[8:4];  // Feeds the next dependent issue.
    endtask

    task automatic random_op_imm();
        logic [2:0]  f3;
        logic [11:0] imm;
        rnd = rand_bits(26);
        f3  = rnd[2:0];
        imm = rnd[24:13];
        if (f3 == f3_sll) begin
            imm[11:6] = 6'b000000;
        end else if (f3 == f3_srl_sra) begin
            imm[11:6] = imm[11] ? 6'b010000 : 6'b000000;  // srai or srli.
        end
        issue(enc_i(imm, rnd[25] ? last_rd : rnd[12:8], f3, rnd[7:3]));
        last_rd = rnd[7:3];
    endtask

    task automatic illegal_trio();
        rnd = rand_bits(32);
        if (rnd[6:0] == opc_op || rnd[6:0] == opc_op_imm || rnd[6:0] == opc_lui) begin
            rnd[6] = 1'b1;  // None of the three has bit 6 set.
        end
        issue(rnd);
        rnd = rand_bits(32);
        issue(enc_r(rnd[31:25] | 7'h01, rnd[24:20], rnd[19:15], rnd[14:12], rnd[11:7]));
        issue(enc_i({rnd[5:0] | 6'h01, rnd[11:6]}, rnd[19:15],
                    rnd[12] ? f3_srl_sra : f3_sll, rnd[11:7]));
    endtask

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        arst_n     = 1'b0;
        lfsr       = 16'd51314;
        last_rd    = '0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        idle(3);
        read_all_regs();
        for (int r = 1; r < 32; r++) begin
            rnd = rand_bits(32);
            issue({rnd[31:12], reg_idx_t'(r), opc_lui});
            issue(enc_i(rnd[11:0], reg_idx_t'(r), f3_xor, reg_idx_t'(r)));
        end
        issue(enc_r(f7_base, 5'd2, 5'd1, f3_add_sub, 5'd0));  // add x0, x1, x2.
        issue(enc_i(12'h000, 5'd0, f3_or, 5'd5));
        for (int k = 0; k < 8; k++) begin
            rnd = rand_bits(24);
            issue({1'b1, rnd[18:0], rnd[23:19], opc_lui});
        end
        idle(2);
        repeat (300) random_op();
        idle(2);
        repeat (200) random_op_imm();
        idle(2);
        repeat (10) illegal_trio();
        read_all_regs();
        idle(3);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

//--- sim/int_core_checker.sv
`timescale 1ns/100ps

module int_core_checker import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     inst_valid,
    input  inst_t    inst,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    input  logic     illegal,
    output int       checks,
    output int       errors
);

    word_t    model [32];
    logic     exp_issued;
    logic     exp_legal;
    reg_idx_t exp_rd;
    word_t    exp_data;
    int       n_checks = 0;
    int       n_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    // Returns the expected retirement and commits it to the model.
    function automatic logic ref_retire(input inst_t i, output reg_idx_t rd, output word_t data);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        logic [5:0] sh;
        logic       ok;
        f3   = i[14:12];
        f7   = i[31:25];
        rd   = i[11:7];
        a    = model[i[19:15]];
        ok   = 1'b0;
        data = '0;
        if (i[6:0] == opc_op) begin
            b  = model[i[24:20]];
            ok = (f7 == f7_base) ||
                 ((f7 == f7_alt) && ((f3 == f3_add_sub) || (f3 == f3_srl_sra)));
        end else begin
            b  = {{52{i[31]}}, i[31:20]};  // I immediate.
            ok = (i[6:0] == opc_op_imm);
            if (ok && (f3 == f3_sll)) begin
                ok = (i[31:26] == 6'b000000);
            end else if (ok && (f3 == f3_srl_sra)) begin
                ok = (i[31:26] == 6'b000000) || (i[31:26] == 6'b010000);
            end
        end
        sh = b[5:0];
        case (f3)
            f3_add_sub: data = (i[6:0] == opc_op && f7[5]) ? a - b : a + b;
            f3_sll:     data = a << sh;
            f3_slt:     data = {63'b0, $signed(a) < $signed(b)};
            f3_sltu:    data = {63'b0, a < b};
            f3_xor:     data = a ^ b;
            f3_srl_sra: begin
                if (i[30]) begin
                    data = $signed(a) >>> sh;   // Sign fill.
                end else begin
                    data = a >> sh;
                end
            end
            f3_or:      data = a | b;
            default:    data = a & b;
        endcase
        if (i[6:0] == opc_lui) begin
            ok   = 1'b1;
            data = {{32{i[31]}}, i[31:12], 12'b0};
        end
        if (ok && (rd != 5'd0)) begin
            model[rd] = data;
        end
        return ok;
    endfunction

    task automatic flag_mismatch(input string msg);
        n_errors++;
        $display("CHECK FAILED @ %0t: %s", $time, msg);
    endtask

    // Expectation is taken where the DUT accepts the instruction.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < 32; r++) begin
                model[r] = '0;
            end
            exp_issued = 1'b0;
        end else begin
            exp_issued = inst_valid;
            if (inst_valid) begin
                exp_legal = ref_retire(inst, exp_rd, exp_data);
            end
        end
    end

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (arst_n) begin
            n_checks++;
            if (!exp_issued) begin
                if (wb_valid !== 1'b0 || illegal !== 1'b0) begin
                    flag_mismatch($sformatf("pulse without issue, wb_valid=%b illegal=%b",
                                            wb_valid, illegal));
                end
            end else if (exp_legal) begin
                if (wb_valid !== 1'b1 || illegal !== 1'b0 || wb_rd !== exp_rd ||
                    wb_data !== exp_data) begin
                    flag_mismatch($sformatf("retire x%0d=%h, got v=%b ill=%b x%0d=%h",
                                            exp_rd, exp_data, wb_valid, illegal,
                                            wb_rd, wb_data));
                end
            end else if (illegal !== 1'b1 || wb_valid !== 1'b0) begin
                flag_mismatch($sformatf("illegal expected, got wb_valid=%b illegal=%b",
                                        wb_valid, illegal));
            end
        end
    end

endmodule

//--- hw/int_core.sv
`timescale 1ns/100ps

module int_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     inst_valid,
    input  inst_t    inst,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     illegal
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     writes_rd;
    logic     rs1_en;
    logic     rs2_en;
    logic     inst_illegal;

    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_b;
    word_t    result;
    logic     rf_w_en;

    inst_decoder u_inst_decoder (
        .inst         (inst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .writes_rd    (writes_rd),
        .rs1_en       (rs1_en),
        .rs2_en       (rs2_en),
        .inst_illegal (inst_illegal)
    );

    // Writeback lands at the edge ending the issue cycle, so no forwarding.
    assign rf_w_en = inst_valid && writes_rd && !inst_illegal && (rd != '0);

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .w_en    (rf_w_en),
        .w_addr  (rd),
        .w_data  (result),
        .r_en1   (rs1_en),
        .r_addr1 (rs1),
        .r_data1 (rs1_data),
        .r_en2   (rs2_en),
        .r_addr2 (rs2),
        .r_data2 (rs2_data)
    );

    assign alu_b = use_imm ? imm : rs2_data;

    alu u_alu (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (result)
    );

    // Retire strobes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= inst_valid && !inst_illegal;
            illegal  <= inst_valid && inst_illegal;
        end
    end

    // Retire payload. An x0 destination still reports its result.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rd   <= '0;
            wb_data <= '0;
        end else if (inst_valid) begin
            wb_rd   <= rd;
            wb_data <= result;
        end
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu import rv_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    shamt_t          shamt;
    word_t           sum;
    logic [xlen:0]   diff_ext;   // One extra bit for the borrow.
    logic            lt;
    logic            ltu;
    logic signed [xlen-1:0] a_signed;

    assign shamt    = b[5:0];
    assign a_signed = a;

    assign sum      = a + b;
    assign diff_ext = {1'b0, a} - {1'b0, b};

    // Borrow out gives unsigned compare.
    assign ltu = diff_ext[xlen];

    // Differing signs decide directly, otherwise the difference sign.
    assign lt = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : diff_ext[xlen-1];

    always_comb begin
        case (op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = diff_ext[xlen-1:0];
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, ltu};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = word_t'(a_signed >>> shamt);   // Sign fill.
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import rv_pkg::*; (
    input  inst_t    inst,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_e  alu_op,
    output logic     use_imm,
    output logic     writes_rd,
    output logic     rs1_en,
    output logic     rs2_en,
    output logic     inst_illegal
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_u;
    logic    legal;

    // Common mapping of funct3 to an ALU operation; alt selects sub or sra.
    function automatic alu_op_e f3_to_op(input funct3_t f3, input logic alt);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        legal   = 1'b0;
        alu_op  = alu_add;
        use_imm = 1'b0;
        imm     = imm_i;
        rs1_en  = 1'b0;
        rs2_en  = 1'b0;

        case (opcode)
            opc_op: begin
                // Only add/sub and srl/sra have an alternate form.
                if (funct7 == f7_base) begin
                    legal = 1'b1;
                end else if (funct7 == f7_alt) begin
                    legal = (funct3 == f3_add_sub) || (funct3 == f3_srl_sra);
                end
                alu_op = f3_to_op(funct3, funct7[5]);
                rs1_en = legal;
                rs2_en = legal;
            end

            opc_op_imm: begin
                case (funct3)
                    f3_sll:     legal = (inst[31:26] == f6_srli);
                    f3_srl_sra: legal = (inst[31:26] == f6_srli) ||
                                        (inst[31:26] == f6_srai);
                    default:    legal = 1'b1;
                endcase
                // No subi, so bit 30 only matters for right shifts.
                alu_op  = f3_to_op(funct3, (funct3 == f3_srl_sra) && inst[30]);
                use_imm = 1'b1;
                rs1_en  = legal;
            end

            opc_lui: begin
                legal   = 1'b1;
                alu_op  = alu_pass_b;
                use_imm = 1'b1;
                imm     = imm_u;
            end

            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign writes_rd    = legal;
    assign inst_illegal = !legal;

endmodule

//--- hw/regfile.sv
`timescale 1ns/100ps

module regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     w_en,
    input  reg_idx_t w_addr,
    input  word_t    w_data,
    input  logic     r_en1,
    input  reg_idx_t r_addr1,
    output word_t    r_data1,
    input  logic     r_en2,
    input  reg_idx_t r_addr2,
    output word_t    r_data2
);

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

    always_comb begin
        if (r_en1 && (r_addr1 != '0)) begin
            r_data1 = regs[r_addr1];
        end else begin
            r_data1 = '0;   // Disabled or x0.
        end
    end

    always_comb begin
        if (r_en2 && (r_addr2 != '0)) begin
            r_data2 = regs[r_addr2];
        end else begin
            r_data2 = '0;
        end
    end

endmodule

//--- common/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [5:0]      shamt_t;   // Shift amount for 64-bit operands.

    // ALU operations. pass_b serves LUI.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Major opcodes.
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;

    // funct3 encodings shared by OP and OP-IMM.
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // funct7 encodings.
    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000;   // sub, sra.

    // Upper six bits of funct7 for the RV64 immediate shifts.
    localparam logic [5:0] f6_srli = 6'b000000;
    localparam logic [5:0] f6_srai = 6'b010000;

endpackage
